// File: logic/sysboard_pkg.sv
// ==================================================
// sysboard_pkg
// shared widths, port addresses, switch settings
// and speaker tone constants for the I/O glue
// ==================================================
package sysboard_pkg;

   // bus widths
   localparam int IO_ADDR_W = 10;
   localparam int IO_DATA_W = 8;
   localparam int TONE_W    = 12;

   typedef logic [IO_ADDR_W-1:0] io_addr_t;   // xa[9:0]
   typedef logic [IO_DATA_W-1:0] io_data_t;   // xd[7:0]
   typedef logic [TONE_W-1:0]    tone_count_t;
   typedef logic [1:0]           ppi_port_t;  // xa[1:0] within 60h..63h

   // 3-to-8 decoder outputs, picked by xa[7:5]
   localparam logic [2:0] DEV_PPI = 3'd3;     // 60h..7Fh
   localparam logic [2:0] DEV_NMI = 3'd5;     // A0h..BFh

   // config switches, a switch that is off reads as 1
   localparam io_data_t   SW1_PATTERN     = 8'h2C;
   localparam logic [3:0] SW2_LOW_NIBBLE  = 4'b0110;  // pb[2] = 1
   localparam logic [3:0] SW2_HIGH_NIBBLE = 4'b1110;  // pb[2] = 0

   // fixed pitch tone in place of timer channel 2
   localparam tone_count_t SPK_RELOAD   = 12'h533;
   localparam tone_count_t SPK_HIGH_MIN = 12'h299;
   localparam int          SPK_PRESCALE = 2;          // clk cycles per count
   localparam int          SPK_PRESCALE_W =
      (SPK_PRESCALE > 1) ? $clog2(SPK_PRESCALE) : 1;

   // port B bit positions
   localparam int PB_TONE_GATE = 0;
   localparam int PB_SPKR_DATA = 1;
   localparam int PB_SW_SELECT = 2;
   localparam int PB_IOCK_DIS  = 5;
   localparam int PB_SW1_READ  = 7;

endpackage

// File: logic/io_decode.sv
// ==================================================
// io_decode
// turns the bus strobes into single access pulses,
// decodes the device and owns the read data enable
// ==================================================
module io_decode import sysboard_pkg::*; (
   input  logic      clk,
   input  logic      reset_n,
   input  io_addr_t  xa_i,
   input  logic      aen_i,       // high while DMA owns the bus
   input  logic      xior_n_i,
   input  logic      xiow_n_i,
   output logic      ppi_rd_o,
   output logic      ppi_wr_o,
   output logic      nmi_wr_o,
   output ppi_port_t ppi_port_o,
   output logic      xd_oe_o
);

   logic       xior_q;     // strobe level seen at the last edge
   logic       xiow_q;
   logic       rd_start;
   logic       wr_start;
   logic       dev_en;
   logic [2:0] dev_num;
   logic       ppi_sel;
   logic       nmi_sel;
   logic       oe_q;

   // decoder enables: xa9, xa8 and aen all low
   assign dev_en  = ~xa_i[9] & ~xa_i[8] & ~aen_i;
   assign dev_num = xa_i[7:5];
   assign ppi_sel = dev_en && (dev_num == DEV_PPI);
   assign nmi_sel = dev_en && (dev_num == DEV_NMI);

   // strobe low now, high at the previous edge
   assign rd_start = ~xior_n_i & xior_q;
   assign wr_start = ~xiow_n_i & xiow_q;

   assign ppi_rd_o   = rd_start & ppi_sel;
   assign ppi_wr_o   = wr_start & ppi_sel;
   assign nmi_wr_o   = wr_start & nmi_sel;   // write only, no readback
   assign ppi_port_o = xa_i[1:0];            // ports alias across the window
   assign xd_oe_o    = oe_q;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         xior_q <= 1'b1;   // strobes idle high
         xiow_q <= 1'b1;
      end else begin
         xior_q <= xior_n_i;
         xiow_q <= xiow_n_i;
      end
   end

   // drive the bus from the access edge until the read strobe is seen high
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         oe_q <= 1'b0;
      end else if (ppi_rd_o) begin
         oe_q <= 1'b1;
      end else if (xior_n_i) begin
         oe_q <= 1'b0;
      end
   end

endmodule

// File: logic/ppi_ports.sv
// ==================================================
// ppi_ports
// port B control register and the port A/C readback
// of the peripheral interface, registered read data
// ==================================================
module ppi_ports import sysboard_pkg::*; (
   input  logic      clk,
   input  logic      reset_n,
   input  logic      ppi_rd_i,
   input  logic      ppi_wr_i,
   input  ppi_port_t ppi_port_i,
   input  io_data_t  xd_i,
   input  logic      tone_i,        // speaker tone level
   input  logic      io_ck_i,       // latched channel check
   output io_data_t  xd_o,
   output logic      tone_gate_o,
   output logic      spkr_data_o,
   output logic      io_ck_dis_o
);

   localparam ppi_port_t PORT_A = 2'd0;
   localparam ppi_port_t PORT_B = 2'd1;
   localparam ppi_port_t PORT_C = 2'd2;

   io_data_t   pb_q;
   io_data_t   port_a;
   io_data_t   port_c;
   io_data_t   rd_data;
   logic [3:0] sw_nibble;
   io_data_t   xd_q;

   // port B, the only writable port
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pb_q <= '0;
      end else if (ppi_wr_i && (ppi_port_i == PORT_B)) begin
         pb_q <= xd_i;
      end
   end

   assign tone_gate_o = pb_q[PB_TONE_GATE];
   assign spkr_data_o = pb_q[PB_SPKR_DATA];
   assign io_ck_dis_o = pb_q[PB_IOCK_DIS];

   // keyboard is gone, so pb7 low reads 00h
   assign port_a = pb_q[PB_SW1_READ] ? SW1_PATTERN : '0;

   // second switch bank, one nibble at a time
   assign sw_nibble = pb_q[PB_SW_SELECT] ? SW2_LOW_NIBBLE : SW2_HIGH_NIBBLE;

   // bit 7 is parity check, no memory here
   assign port_c = {1'b0, io_ck_i, tone_i, ~tone_i, sw_nibble};

   always_comb begin
      case (ppi_port_i)
         PORT_A:  rd_data = port_a;
         PORT_B:  rd_data = pb_q;
         PORT_C:  rd_data = port_c;
         default: rd_data = '0;    // 63h mode control
      endcase
   end

   // loaded at the access edge, held while the bus is released
   always_ff @(posedge clk) begin
      if (ppi_rd_i) begin
         xd_q <= rd_data;
      end
   end

   assign xd_o = xd_q;

endmodule

// File: logic/speaker_tone.sv
// ==================================================
// speaker_tone
// fixed pitch tone from a prescaled reloading
// down-counter, gated and mixed into the speaker
// ==================================================
module speaker_tone import sysboard_pkg::*; (
   input  logic clk,
   input  logic reset_n,
   input  logic tone_gate_i,   // pb[0]
   input  logic spkr_data_i,   // pb[1]
   output logic tone_o,
   output logic spkr_o
);

   logic [SPK_PRESCALE_W-1:0] pre_q;
   logic                      step;
   tone_count_t               cnt_q;
   logic                      tone_hi;

   assign step = (pre_q == SPK_PRESCALE_W'(SPK_PRESCALE - 1));

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pre_q <= '0;
      end else if (step) begin
         pre_q <= '0;
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   // free running, reload after 0
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         cnt_q <= SPK_RELOAD;
      end else if (step) begin
         if (cnt_q == '0) begin
            cnt_q <= SPK_RELOAD;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   assign tone_hi = (cnt_q >= SPK_HIGH_MIN);

   // gate low holds the output high, as timer mode 3 does
   assign tone_o = tone_gate_i ? tone_hi : 1'b1;
   assign spkr_o = tone_o & spkr_data_i;

endmodule

// File: logic/nmi_gate.sv
// ==================================================
// nmi_gate
// NMI mask register and I/O channel check latch
// ==================================================
module nmi_gate (
   input  logic clk,
   input  logic reset_n,
   input  logic nmi_wr_i,       // write pulse for A0h
   input  logic xd7_i,
   input  logic io_ch_ck_n_i,   // channel check from the slots
   input  logic io_ck_dis_i,    // pb[5]
   output logic io_ck_o,
   output logic nmi_o
);

   logic mask_q;
   logic io_ck_q;

   // only data bit 7 is kept
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
      end else if (nmi_wr_i) begin
         mask_q <= xd7_i;
      end
   end

   // disable also clears a pending check
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         io_ck_q <= 1'b0;
      end else if (io_ck_dis_i) begin
         io_ck_q <= 1'b0;
      end else if (!io_ch_ck_n_i) begin
         io_ck_q <= 1'b1;
      end
   end

   assign io_ck_o = io_ck_q;
   assign nmi_o   = mask_q & io_ck_q;

endmodule

// File: logic/sysboard_io.sv
// ==================================================
// sysboard_io
// top of the I/O glue: decode, peripheral ports,
// speaker tone and NMI logic
// ==================================================
module sysboard_io import sysboard_pkg::*; (
   input  logic     clk,
   input  logic     reset_n,
   input  io_addr_t xa_i,
   input  io_data_t xd_i,
   input  logic     xior_n_i,
   input  logic     xiow_n_i,
   input  logic     aen_i,
   input  logic     io_ch_ck_n_i,
   output io_data_t xd_o,
   output logic     xd_oe_o,
   output logic     spkr_o,
   output logic     nmi_o
);

   logic      ppi_rd;
   logic      ppi_wr;
   logic      nmi_wr;
   ppi_port_t ppi_port;
   logic      tone_gate;   // pb[0]
   logic      spkr_data;   // pb[1]
   logic      io_ck_dis;   // pb[5]
   logic      tone;
   logic      io_ck;

   io_decode u_io_decode (
      .clk        (clk),
      .reset_n    (reset_n),
      .xa_i       (xa_i),
      .aen_i      (aen_i),
      .xior_n_i   (xior_n_i),
      .xiow_n_i   (xiow_n_i),
      .ppi_rd_o   (ppi_rd),
      .ppi_wr_o   (ppi_wr),
      .nmi_wr_o   (nmi_wr),
      .ppi_port_o (ppi_port),
      .xd_oe_o    (xd_oe_o)
   );

   ppi_ports u_ppi_ports (
      .clk         (clk),
      .reset_n     (reset_n),
      .ppi_rd_i    (ppi_rd),
      .ppi_wr_i    (ppi_wr),
      .ppi_port_i  (ppi_port),
      .xd_i        (xd_i),
      .tone_i      (tone),
      .io_ck_i     (io_ck),
      .xd_o        (xd_o),
      .tone_gate_o (tone_gate),
      .spkr_data_o (spkr_data),
      .io_ck_dis_o (io_ck_dis)
   );

   speaker_tone u_speaker_tone (
      .clk         (clk),
      .reset_n     (reset_n),
      .tone_gate_i (tone_gate),
      .spkr_data_i (spkr_data),
      .tone_o      (tone),
      .spkr_o      (spkr_o)
   );

   nmi_gate u_nmi_gate (
      .clk          (clk),
      .reset_n      (reset_n),
      .nmi_wr_i     (nmi_wr),
      .xd7_i        (xd_i[7]),   // mask bit
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .io_ck_dis_i  (io_ck_dis),
      .io_ck_o      (io_ck),
      .nmi_o        (nmi_o)
   );

endmodule

// File: test/sysboard_io_sva.sv
// ==================================================
// io_decode_sva
// access pulse checks bound into the I/O decoder
// ==================================================
module io_decode_sva (
   input logic clk,
   input logic reset_n,
   input logic aen_i,
   input logic ppi_rd_i,
   input logic ppi_wr_i,
   input logic nmi_wr_i
);

   // each access gives a single cycle pulse
   rd_pulse_one: assert property (@(posedge clk) disable iff (!reset_n)
      ppi_rd_i |=> !ppi_rd_i)
      else $error("ppi_rd_o high for more than one cycle");

   wr_pulse_one: assert property (@(posedge clk) disable iff (!reset_n)
      ppi_wr_i |=> !ppi_wr_i)
      else $error("ppi_wr_o high for more than one cycle");

   nmi_pulse_one: assert property (@(posedge clk) disable iff (!reset_n)
      nmi_wr_i |=> !nmi_wr_i)
      else $error("nmi_wr_o high for more than one cycle");

   pulse_excl: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0({ppi_rd_i, ppi_wr_i, nmi_wr_i}))
      else $error("more than one access pulse at once");

   // DMA cycles never reach a device
   no_dma_access: assert property (@(posedge clk) disable iff (!reset_n)
      aen_i |-> !(ppi_rd_i | ppi_wr_i | nmi_wr_i))
      else $error("access pulse while aen_i is high");

endmodule

bind io_decode io_decode_sva u_io_decode_sva (
   .clk      (clk),
   .reset_n  (reset_n),
   .aen_i    (aen_i),
   .ppi_rd_i (ppi_rd_o),
   .ppi_wr_i (ppi_wr_o),
   .nmi_wr_i (nmi_wr_o)
);

// File: test/tb_sysboard_io.sv
// ==================================================
// tb_sysboard_io
// testbench for the I/O glue: bus accesses, switch
// readback, speaker runs, NMI path and read timing
// ==================================================
module tb_sysboard_io import sysboard_pkg::*; ();

   localparam int CLK_HALF   = 20;
   localparam int DRIVE_DLY  = 5;     // inputs change after the edge
   localparam int RESET_CYC  = 16;
   localparam int STROBE_CYC = 3;     // edges that see a strobe low
   localparam logic [31:0] SEED = 32'd33;

   // tone runs in clk cycles, from the counter range and prescale
   localparam int HIGH_RUN   = (int'(SPK_RELOAD) - int'(SPK_HIGH_MIN) + 1) * SPK_PRESCALE;
   localparam int LOW_RUN    = int'(SPK_HIGH_MIN) * SPK_PRESCALE;
   localparam int SPK_PERIOD = HIGH_RUN + LOW_RUN;
   // speaker checks take about four tone periods, bus tests a few hundred cycles
   localparam int MAX_CYCLES = 20000;

   localparam ppi_port_t PORT_A = 2'd0;
   localparam ppi_port_t PORT_B = 2'd1;
   localparam ppi_port_t PORT_C = 2'd2;
   localparam ppi_port_t PORT_M = 2'd3;   // mode control, reads 00h

   logic     clk;
   logic     reset_n;
   io_addr_t xa_i;
   io_data_t xd_i;
   logic     xior_n_i;
   logic     xiow_n_i;
   logic     aen_i;
   logic     io_ch_ck_n_i;
   io_data_t xd_o;
   logic     xd_oe_o;
   logic     spkr_o;
   logic     nmi_o;

   int          total_cyc = 0;
   int          run_cyc   = 0;    // edges since reset release
   io_data_t    pb_model  = '0;
   logic        iock_model = 1'b0;
   logic        mask_model = 1'b0;
   io_data_t    exp_q[$];
   io_data_t    act_q[$];
   event        rd_done;
   logic [31:0] rnd;
   int          len_a;
   int          len_b;
   logic        lvl_a;
   logic        lvl_b;
   io_data_t    sw_cases[5] = '{8'h80, 8'h00, 8'h84, 8'h05, 8'h01};

   sysboard_io uut (
      .clk          (clk),
      .reset_n      (reset_n),
      .xa_i         (xa_i),
      .xd_i         (xd_i),
      .xior_n_i     (xior_n_i),
      .xiow_n_i     (xiow_n_i),
      .aen_i        (aen_i),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .xd_o         (xd_o),
      .xd_oe_o      (xd_oe_o),
      .spkr_o       (spkr_o),
      .nmi_o        (nmi_o)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic io_addr_t ppi_addr(input ppi_port_t port);
      return {2'b00, DEV_PPI, 3'b000, port};
   endfunction

   // free running tone, high first after reset
   function automatic logic tone_ref(input int cyc, input logic gate);
      if (!gate) begin
         return 1'b1;
      end
      return (cyc % SPK_PERIOD) < HIGH_RUN;
   endfunction

   // expected port byte from the port B model, tone and latch
   function automatic io_data_t port_ref(input ppi_port_t port, input io_data_t pb,
                                         input logic tone, input logic iock);
      logic [3:0] nib;
      nib = pb[PB_SW_SELECT] ? SW2_LOW_NIBBLE : SW2_HIGH_NIBBLE;
      case (port)
         PORT_A:  return pb[PB_SW1_READ] ? SW1_PATTERN : 8'h00;
         PORT_B:  return pb;
         PORT_C:  return {1'b0, iock, tone, ~tone, nib};
         default: return 8'h00;
      endcase
   endfunction

   task automatic stop_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_data(input string name, input io_data_t exp, input io_data_t act);
      if (exp !== act) begin
         $display("ERR %0t %s: expected %02h, actual %02h", $time, name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("ERR %0t %s: expected %b, actual %b", $time, name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (exp != act) begin
         $display("ERR %0t %s: expected %0d, actual %0d", $time, name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic step();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic io_write(input io_addr_t addr, input io_data_t data, input logic aen);
      xa_i     = addr;
      xd_i     = data;
      aen_i    = aen;
      xiow_n_i = 1'b0;
      repeat (STROBE_CYC) begin
         step();
         check_bit("xd_oe_o", 1'b0, xd_oe_o);   // never driven on a write
      end
      xiow_n_i = 1'b1;
      step();
      aen_i = 1'b0;
   endtask

   task automatic write_port_b(input io_data_t data);
      io_write(ppi_addr(PORT_B), data, 1'b0);
      pb_model = data;
      if (data[PB_IOCK_DIS]) begin
         iock_model = 1'b0;
      end
   endtask

   task automatic io_read(input ppi_port_t port);
      io_data_t act;
      int       rd_cyc;
      logic     tone;
      xa_i     = ppi_addr(port);
      aen_i    = 1'b0;
      xior_n_i = 1'b0;
      rd_cyc   = run_cyc;       // tone seen by the access edge
      check_bit("xd_oe_o", 1'b0, xd_oe_o);
      step();
      check_bit("xd_oe_o", 1'b1, xd_oe_o);
      act = xd_o;
      repeat (STROBE_CYC - 1) begin
         step();
         check_bit("xd_oe_o", 1'b1, xd_oe_o);
      end
      xior_n_i = 1'b1;
      check_bit("xd_oe_o", 1'b1, xd_oe_o);
      step();
      check_bit("xd_oe_o", 1'b0, xd_oe_o);    // one cycle after the strobe rises
      check_data("xd_o", act, xd_o);          // held after release
      tone = tone_ref(rd_cyc, pb_model[PB_TONE_GATE]);
      exp_q.push_back(port_ref(port, pb_model, tone, iock_model));
      act_q.push_back(act);
      -> rd_done;
   endtask

   task automatic pulse_channel_check();
      io_ch_ck_n_i = 1'b0;
      step();
      io_ch_ck_n_i = 1'b1;
      if (!pb_model[PB_IOCK_DIS]) begin
         iock_model = 1'b1;
      end
      step();
   endtask

   // length of the current spkr_o run from here to its end
   task automatic measure_run(output int len, output logic lvl);
      lvl = spkr_o;
      len = 0;
      while (spkr_o == lvl) begin
         len = len + 1;
         step();
      end
   endtask

   task automatic hold_check(input logic lvl, input int n);
      repeat (n) begin
         check_bit("spkr_o", lvl, spkr_o);
         step();
      end
   endtask

   // compares every finished read against its reference
   always @(rd_done) begin
      while (exp_q.size() > 0) begin
         check_data("xd_o", exp_q.pop_front(), act_q.pop_front());
      end
   end

   always @(posedge clk) begin
      total_cyc = total_cyc + 1;
      if (reset_n) begin
         run_cyc = run_cyc + 1;
      end
      if (total_cyc > MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         stop_with_failure();
      end
   end

   initial begin
      reset_n      = 1'b0;
      xa_i         = '0;
      xd_i         = '0;
      xior_n_i     = 1'b1;
      xiow_n_i     = 1'b1;
      aen_i        = 1'b0;
      io_ch_ck_n_i = 1'b1;
      repeat (RESET_CYC) @(posedge clk);
      #DRIVE_DLY;
      reset_n = 1'b1;

      // state after reset
      check_bit("xd_oe_o", 1'b0, xd_oe_o);
      check_bit("nmi_o", 1'b0, nmi_o);
      check_bit("spkr_o", 1'b0, spkr_o);
      io_read(PORT_B);

      // port B readback, then writes that must miss
      rnd = SEED;
      repeat (8) begin
         rnd = xorshift32(rnd);
         write_port_b(rnd[7:0]);
         io_read(PORT_B);
      end
      io_write(ppi_addr(PORT_B), ~pb_model, 1'b1);            // DMA cycle
      io_read(PORT_B);
      io_write(ppi_addr(PORT_B) | 10'h300, ~pb_model, 1'b0);  // 361h alias
      io_read(PORT_B);

      // switch banks and port C
      foreach (sw_cases[i]) begin
         write_port_b(sw_cases[i]);
         io_read(PORT_A);
         io_read(PORT_C);
         io_read(PORT_M);
      end

      // speaker runs with gate and data on
      write_port_b(8'h03);
      measure_run(len_a, lvl_a);   // partial run
      measure_run(len_a, lvl_a);
      measure_run(len_b, lvl_b);
      check_bit("spkr_o", tone_ref(run_cyc, 1'b1), spkr_o);   // phase since reset
      check_count("spkr_o run a", lvl_a ? HIGH_RUN : LOW_RUN, len_a);
      check_count("spkr_o run b", lvl_b ? HIGH_RUN : LOW_RUN, len_b);
      write_port_b(8'h02);
      hold_check(1'b1, SPK_PERIOD);
      write_port_b(8'h01);
      hold_check(1'b0, SPK_PERIOD);

      // NMI with mask set
      write_port_b(8'h00);
      io_write({2'b00, DEV_NMI, 5'b00000}, 8'h80, 1'b0);
      mask_model = 1'b1;
      check_bit("nmi_o", 1'b0, nmi_o);
      pulse_channel_check();
      check_bit("nmi_o", mask_model & iock_model, nmi_o);
      io_read(PORT_C);
      write_port_b(8'h20);         // disable clears the latch
      check_bit("nmi_o", 1'b0, nmi_o);
      io_read(PORT_C);
      pulse_channel_check();       // ignored while disabled
      check_bit("nmi_o", 1'b0, nmi_o);
      io_read(PORT_C);

      // mask cleared, latch still sets
      write_port_b(8'h00);
      io_write({2'b00, DEV_NMI, 5'b00000}, 8'h00, 1'b0);
      mask_model = 1'b0;
      pulse_channel_check();
      check_bit("nmi_o", 1'b0, nmi_o);
      io_read(PORT_C);
      hold_check(1'b0, 4);
      check_bit("nmi_o", 1'b0, nmi_o);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: sources.f
logic/sysboard_pkg.sv
logic/io_decode.sv
logic/ppi_ports.sv
logic/speaker_tone.sv
logic/nmi_gate.sv
logic/sysboard_io.sv
test/sysboard_io_sva.sv
test/tb_sysboard_io.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_sysboard_io \
   --Mdir obj_dir -o sim_tb_sysboard_io \
   && ./obj_dir/sim_tb_sysboard_io \
   || { echo "simulation run did not complete cleanly"; exit 1; }
